// File: source/kernel_pkg.sv
// Kernel package
// Shared word, address and count types for the read kernel,
// the controller state encoding and the build constants
`default_nettype none

package kernel_pkg;

  // ------------------------------------------------------------
  // Data path widths
  // ------------------------------------------------------------
  // One memory word, also the width of sums and maxima
  typedef logic [31:0] word_t;

  // Word address on a memory port and in a buffer argument
  typedef logic [31:0] addr_t;

  // Number of words one channel reads per run
  typedef logic [15:0] count_t;

  // ------------------------------------------------------------
  // Controller FSM
  // ------------------------------------------------------------
  // Idle waits for ap_start, run waits for both engines,
  // done holds ap_done until ap_continue
  typedef enum logic [1:0] {
    CTRL_IDLE = 2'd0,
    CTRL_RUN  = 2'd1,
    CTRL_DONE = 2'd2
  } ctrl_state_t;

  // ------------------------------------------------------------
  // Build constants
  // ------------------------------------------------------------
  // Internal reset window after ap_rst_n releases, in cycles
  localparam int RESET_HOLD_CYCLES = 16;

  // Read channels in the kernel
  localparam int NUM_CHANNELS = 2;

endpackage : kernel_pkg

`default_nettype wire

// File: source/kernel_reset_sync.sv
// Kernel reset stretcher
// Turns the host ap_rst_n into an active high internal reset that
// stays on for a fixed window after ap_rst_n is released
`timescale 1ns/1ps
`default_nettype none

module kernel_reset_sync #(
  parameter int HOLD_CYCLES = 16
) (
  input  wire  ap_clk,
  input  wire  ap_rst_n,
  output logic areset
);

  // Counter wide enough for the whole hold window
  localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

  logic [CNT_W-1:0] hold_cnt;

  // Assert at once on ap_rst_n low, release on a clock edge
  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      hold_cnt <= '0;
      areset   <= 1'b1;
    end else if (areset) begin
      // Last cycle of the window drops areset
      if (hold_cnt == CNT_W'(HOLD_CYCLES - 1)) begin
        areset <= 1'b0;
      end else begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

  // Internal reset ends only once the host reset has stayed released
  // for the whole hold window
  areset_release_check : assert property (@(posedge ap_clk)
    $fell(areset) |-> ap_rst_n && $past(ap_rst_n, HOLD_CYCLES));

endmodule : kernel_reset_sync

`default_nettype wire

// File: source/kernel_read_engine.sv
// Channel read engine
// Streams count words from base upward over a request/response port,
// keeps several reads in flight, and accumulates a running sum and
// maximum of the returned words
`timescale 1ns/1ps
`default_nettype none

module kernel_read_engine (
  input  wire                 ap_clk,
  input  wire                 areset,
  input  wire                 start,
  input  wire kernel_pkg::addr_t  base,
  input  wire kernel_pkg::count_t count,
  // Memory port
  output logic                mem_req,
  output kernel_pkg::addr_t   mem_addr,
  input  wire                 mem_ready,
  input  wire                 mem_rvalid,
  input  wire kernel_pkg::word_t  mem_rdata,
  // Results to the controller
  output logic                done,
  output kernel_pkg::word_t   sum,
  output kernel_pkg::word_t   max
);

  // ------------------------------------------------------------
  // Run tracking
  // ------------------------------------------------------------
  logic               busy;
  // Reads still to issue
  kernel_pkg::count_t issue_left;
  // Responses still to collect
  kernel_pkg::count_t recv_left;

  // Request held until accepted, address moves only on acceptance
  assign mem_req = busy && (issue_left != '0);

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      busy       <= 1'b0;
      issue_left <= '0;
      recv_left  <= '0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        issue_left <= count;
        recv_left  <= count;
        // Empty run reports done one cycle after start
        busy       <= (count != '0);
        done       <= (count == '0);
      end else if (busy) begin
        if (mem_req && mem_ready) begin
          issue_left <= issue_left - 1'b1;
        end
        if (mem_rvalid) begin
          recv_left <= recv_left - 1'b1;
          // Final response closes the run
          if (recv_left == kernel_pkg::count_t'(1)) begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Address and accumulators
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (start) begin
      mem_addr <= base;
      sum      <= '0;
      max      <= '0;
    end else begin
      if (mem_req && mem_ready) begin
        mem_addr <= mem_addr + 1'b1;
      end
      if (mem_rvalid) begin
        // Sum wraps modulo 2**32
        sum <= sum + mem_rdata;
        if (mem_rdata > max) begin
          max <= mem_rdata;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // A response needs an accepted read still waiting
  rvalid_outstanding_check : assert property (@(posedge ap_clk) disable iff (areset)
    mem_rvalid |-> busy && (recv_left != issue_left));

  // Controller must not restart a running channel
  start_idle_check : assert property (@(posedge ap_clk) disable iff (areset)
    start |-> !busy);

endmodule : kernel_read_engine

`default_nettype wire

// File: source/kernel_control.sv
// Kernel controller
// ap_ctrl_chain FSM that latches the buffer arguments, starts both
// read engines, waits for both to finish and holds the combined
// sum and maximum with ap_done until the host acknowledges
`timescale 1ns/1ps
`default_nettype none

module kernel_control (
  input  wire                ap_clk,
  input  wire                areset,
  input  wire                ap_start,
  input  wire                ap_continue,
  output logic               ap_idle,
  output logic               ap_ready,
  output logic               ap_done,
  // Buffer arguments
  input  wire kernel_pkg::addr_t buffer_0,
  input  wire kernel_pkg::addr_t buffer_1,
  input  wire kernel_pkg::addr_t buffer_2,
  input  wire kernel_pkg::addr_t buffer_3,
  // Engine launch
  output logic               start,
  output kernel_pkg::addr_t  base_0,
  output kernel_pkg::count_t count_0,
  output kernel_pkg::addr_t  base_1,
  output kernel_pkg::count_t count_1,
  // Engine results
  input  wire                done_0,
  input  wire kernel_pkg::word_t sum_0,
  input  wire kernel_pkg::word_t max_0,
  input  wire                done_1,
  input  wire kernel_pkg::word_t sum_1,
  input  wire kernel_pkg::word_t max_1,
  // Combined results
  output kernel_pkg::word_t  result_sum,
  output kernel_pkg::word_t  result_max
);

  kernel_pkg::ctrl_state_t state;

  // Sticky per-channel done, one bit per engine
  logic [kernel_pkg::NUM_CHANNELS-1:0] done_flag;
  logic [kernel_pkg::NUM_CHANNELS-1:0] done_seen;

  // Flags plus any done arriving this cycle
  assign done_seen = done_flag | {done_1, done_0};

  // ------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state     <= kernel_pkg::CTRL_IDLE;
      ap_idle   <= 1'b1;
      ap_ready  <= 1'b0;
      ap_done   <= 1'b0;
      start     <= 1'b0;
      done_flag <= '0;
    end else begin
      // Single-cycle strobes
      ap_ready <= 1'b0;
      start    <= 1'b0;
      case (state)
        kernel_pkg::CTRL_IDLE: begin
          if (ap_start) begin
            state     <= kernel_pkg::CTRL_RUN;
            ap_ready  <= 1'b1;
            ap_idle   <= 1'b0;
            start     <= 1'b1;
            done_flag <= '0;
          end
        end
        kernel_pkg::CTRL_RUN: begin
          done_flag <= done_seen;
          if (&done_seen) begin
            state   <= kernel_pkg::CTRL_DONE;
            ap_done <= 1'b1;
          end
        end
        kernel_pkg::CTRL_DONE: begin
          // Hold results until the host acknowledges
          if (ap_continue) begin
            state   <= kernel_pkg::CTRL_IDLE;
            ap_done <= 1'b0;
            ap_idle <= 1'b1;
          end
        end
        default: begin
          state <= kernel_pkg::CTRL_IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Descriptor and results
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    // Arguments taken on the same edge as ap_ready
    if (state == kernel_pkg::CTRL_IDLE && ap_start) begin
      base_0  <= buffer_0;
      count_0 <= buffer_1[15:0];
      base_1  <= buffer_2;
      count_1 <= buffer_3[15:0];
    end
    // Engines hold sum and max after their done pulse
    if (state == kernel_pkg::CTRL_RUN && (&done_seen)) begin
      result_sum <= sum_0 + sum_1;
      result_max <= (max_0 > max_1) ? max_0 : max_1;
    end
  end

  // Acceptance and completion never share a cycle
  ready_done_check : assert property (@(posedge ap_clk) disable iff (areset)
    !(ap_ready && ap_done));

endmodule : kernel_control

`default_nettype wire

// File: source/kernel_afu.sv
// Kernel top level
// Host control and arguments in, two read channels out to memory;
// reset stretcher, controller and one read engine per channel
`timescale 1ns/1ps
`default_nettype none

module kernel_afu (
  input  wire                ap_clk,
  input  wire                ap_rst_n,
  // ap_ctrl_chain
  input  wire                ap_start,
  input  wire                ap_continue,
  output logic               ap_idle,
  output logic               ap_ready,
  output logic               ap_done,
  // Arguments
  input  wire kernel_pkg::addr_t buffer_0,
  input  wire kernel_pkg::addr_t buffer_1,
  input  wire kernel_pkg::addr_t buffer_2,
  input  wire kernel_pkg::addr_t buffer_3,
  // Results
  output kernel_pkg::word_t  result_sum,
  output kernel_pkg::word_t  result_max,
  // Channel 0 memory port
  output logic               mem_0_req,
  output kernel_pkg::addr_t  mem_0_addr,
  input  wire                mem_0_ready,
  input  wire                mem_0_rvalid,
  input  wire kernel_pkg::word_t mem_0_rdata,
  // Channel 1 memory port
  output logic               mem_1_req,
  output kernel_pkg::addr_t  mem_1_addr,
  input  wire                mem_1_ready,
  input  wire                mem_1_rvalid,
  input  wire kernel_pkg::word_t mem_1_rdata
);

  // ------------------------------------------------------------
  // Internal wires
  // ------------------------------------------------------------
  logic areset;
  logic engine_start;

  // Launch descriptor per channel
  kernel_pkg::addr_t  engine_base  [kernel_pkg::NUM_CHANNELS];
  kernel_pkg::count_t engine_count [kernel_pkg::NUM_CHANNELS];

  // Per channel results back to the controller
  logic [kernel_pkg::NUM_CHANNELS-1:0] engine_done;
  kernel_pkg::word_t  engine_sum   [kernel_pkg::NUM_CHANNELS];
  kernel_pkg::word_t  engine_max   [kernel_pkg::NUM_CHANNELS];

  // ------------------------------------------------------------
  // Reset and control
  // ------------------------------------------------------------
  kernel_reset_sync #(
    .HOLD_CYCLES(kernel_pkg::RESET_HOLD_CYCLES)
  ) inst_kernel_reset_sync (
    .ap_clk  (ap_clk),
    .ap_rst_n(ap_rst_n),
    .areset  (areset)
  );

  kernel_control inst_kernel_control (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .ap_start   (ap_start),
    .ap_continue(ap_continue),
    .ap_idle    (ap_idle),
    .ap_ready   (ap_ready),
    .ap_done    (ap_done),
    .buffer_0   (buffer_0),
    .buffer_1   (buffer_1),
    .buffer_2   (buffer_2),
    .buffer_3   (buffer_3),
    .start      (engine_start),
    .base_0     (engine_base[0]),
    .count_0    (engine_count[0]),
    .base_1     (engine_base[1]),
    .count_1    (engine_count[1]),
    .done_0     (engine_done[0]),
    .sum_0      (engine_sum[0]),
    .max_0      (engine_max[0]),
    .done_1     (engine_done[1]),
    .sum_1      (engine_sum[1]),
    .max_1      (engine_max[1]),
    .result_sum (result_sum),
    .result_max (result_max)
  );

  // ------------------------------------------------------------
  // Read channels
  // ------------------------------------------------------------
  kernel_read_engine inst_kernel_read_engine_0 (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .start     (engine_start),
    .base      (engine_base[0]),
    .count     (engine_count[0]),
    .mem_req   (mem_0_req),
    .mem_addr  (mem_0_addr),
    .mem_ready (mem_0_ready),
    .mem_rvalid(mem_0_rvalid),
    .mem_rdata (mem_0_rdata),
    .done      (engine_done[0]),
    .sum       (engine_sum[0]),
    .max       (engine_max[0])
  );

  kernel_read_engine inst_kernel_read_engine_1 (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .start     (engine_start),
    .base      (engine_base[1]),
    .count     (engine_count[1]),
    .mem_req   (mem_1_req),
    .mem_addr  (mem_1_addr),
    .mem_ready (mem_1_ready),
    .mem_rvalid(mem_1_rvalid),
    .mem_rdata (mem_1_rdata),
    .done      (engine_done[1]),
    .sum       (engine_sum[1]),
    .max       (engine_max[1])
  );

endmodule : kernel_afu

`default_nettype wire

// File: dv/kernel_mem_model.sv
// Testbench memory model for one read channel
// Random acceptance stalls on mem_ready, and read data returned in
// request order after a random latency of 1 to 4 cycles
`timescale 1ns/1ps
`default_nettype none

module kernel_mem_model #(
  parameter int SEED = 1
) (
  input  wire                    ap_clk,
  input  wire                    ap_rst_n,
  input  wire                    mem_req,
  // Memory word at the address currently requested
  input  wire kernel_pkg::word_t req_word,
  output logic                   mem_ready,
  output logic                   mem_rvalid,
  output kernel_pkg::word_t      mem_rdata
);

  // Pending responses, data captured at acceptance
  kernel_pkg::word_t data_q [$];
  // Cycle at which each pending response may go out
  int                due_q  [$];
  int                cycle;
  int                delay;
  int                seed;

  initial seed = SEED;

  always @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      mem_ready  <= 1'b0;
      mem_rvalid <= 1'b0;
      mem_rdata  <= '0;
      cycle = 0;
      data_q.delete();
      due_q.delete();
    end else begin
      cycle = cycle + 1;
      // Accepted read, latency 1 to 4 cycles
      if (mem_req && mem_ready) begin
        delay = 1 + ($random(seed) & 3);
        data_q.push_back(req_word);
        due_q.push_back(cycle + delay);
      end
      // Head blocks later reads, so data stays in order
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        mem_rvalid <= 1'b1;
        mem_rdata  <= data_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        mem_rvalid <= 1'b0;
      end
      // Stall about one cycle in four
      mem_ready <= (($random(seed) & 3) != 0);
    end
  end

endmodule : kernel_mem_model

`default_nettype wire

// File: dv/kernel_afu_tb.sv
// Kernel testbench
// Runs ap_ctrl_chain transactions through the kernel with two modelled
// memory channels and checks the combined sum and maximum
`timescale 1ns/1ps
`default_nettype none

module kernel_afu_tb;

  localparam int MEM_WORDS = 1024;
  localparam int SEED      = 32'h389f_67fc;
  // 24 runs of up to 64 words per channel at about 8 cycles each with margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic ap_clk;
  logic ap_rst_n;
  logic ap_start;
  logic ap_continue;
  logic ap_idle;
  logic ap_ready;
  logic ap_done;
  kernel_pkg::addr_t buffer_0;
  kernel_pkg::addr_t buffer_1;
  kernel_pkg::addr_t buffer_2;
  kernel_pkg::addr_t buffer_3;
  kernel_pkg::word_t result_sum;
  kernel_pkg::word_t result_max;

  // ------------------------------------------------------------
  // Memory channels
  // ------------------------------------------------------------
  logic              mem_0_req;
  kernel_pkg::addr_t mem_0_addr;
  logic              mem_0_ready;
  logic              mem_0_rvalid;
  kernel_pkg::word_t mem_0_rdata;
  logic              mem_1_req;
  kernel_pkg::addr_t mem_1_addr;
  logic              mem_1_ready;
  logic              mem_1_rvalid;
  kernel_pkg::word_t mem_1_rdata;

  // Shared memory with addresses wrapping at 1024 words
  kernel_pkg::word_t mem_array [MEM_WORDS];
  kernel_pkg::word_t word_0;
  kernel_pkg::word_t word_1;

  kernel_pkg::word_t exp_sum;
  kernel_pkg::word_t exp_max;
  int seed;
  int cycle_count  = 0;
  int ready_count  = 0;
  int runs_started = 0;

  assign word_0 = mem_array[mem_0_addr[9:0]];
  assign word_1 = mem_array[mem_1_addr[9:0]];

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  kernel_afu UUT (
    .ap_clk      (ap_clk),
    .ap_rst_n    (ap_rst_n),
    .ap_start    (ap_start),
    .ap_continue (ap_continue),
    .ap_idle     (ap_idle),
    .ap_ready    (ap_ready),
    .ap_done     (ap_done),
    .buffer_0    (buffer_0),
    .buffer_1    (buffer_1),
    .buffer_2    (buffer_2),
    .buffer_3    (buffer_3),
    .result_sum  (result_sum),
    .result_max  (result_max),
    .mem_0_req   (mem_0_req),
    .mem_0_addr  (mem_0_addr),
    .mem_0_ready (mem_0_ready),
    .mem_0_rvalid(mem_0_rvalid),
    .mem_0_rdata (mem_0_rdata),
    .mem_1_req   (mem_1_req),
    .mem_1_addr  (mem_1_addr),
    .mem_1_ready (mem_1_ready),
    .mem_1_rvalid(mem_1_rvalid),
    .mem_1_rdata (mem_1_rdata)
  );

  kernel_mem_model #(.SEED(SEED + 1)) mem_model_0 (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .mem_req   (mem_0_req),
    .req_word  (word_0),
    .mem_ready (mem_0_ready),
    .mem_rvalid(mem_0_rvalid),
    .mem_rdata (mem_0_rdata)
  );

  kernel_mem_model #(.SEED(SEED + 2)) mem_model_1 (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .mem_req   (mem_1_req),
    .req_word  (word_1),
    .mem_ready (mem_1_ready),
    .mem_rvalid(mem_1_rvalid),
    .mem_rdata (mem_1_rdata)
  );

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  // Fold one channel's words into a running sum and maximum
  function automatic void accumulate_channel(
    input kernel_pkg::addr_t  base,
    input kernel_pkg::count_t count,
    inout kernel_pkg::word_t  s,
    inout kernel_pkg::word_t  m
  );
    kernel_pkg::word_t w;
    for (int i = 0; i < int'(count); i++) begin
      w = mem_array[10'(base + 32'(i))];
      s = s + w;
      if (w > m) begin
        m = w;
      end
    end
  endfunction

  function automatic void compute_sum_max(
    input  kernel_pkg::addr_t  b0,
    input  kernel_pkg::count_t c0,
    input  kernel_pkg::addr_t  b1,
    input  kernel_pkg::count_t c1,
    output kernel_pkg::word_t  s,
    output kernel_pkg::word_t  m
  );
    s = '0;
    m = '0;
    accumulate_channel(b0, c0, s, m);
    accumulate_channel(b1, c1, s, m);
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // ------------------------------------------------------------
  // Monitors and checker
  // ------------------------------------------------------------
  always @(posedge ap_clk) begin
    if (ap_ready) begin
      ready_count <= ready_count + 1;
    end
  end

  // Results checked on every cycle ap_done is held
  always @(posedge ap_clk) begin
    if (ap_done) begin
      assert (result_sum == exp_sum) else begin
        report_failure($sformatf("Mismatch at %0t: result_sum %h, expected %h",
                                 $time, result_sum, exp_sum));
      end
      assert (result_max == exp_max) else begin
        report_failure($sformatf("Mismatch at %0t: result_max %h, expected %h",
                                 $time, result_max, exp_max));
      end
      assert (!ap_idle && !ap_ready) else begin
        report_failure("ap_idle or ap_ready was high while ap_done was held");
      end
    end
  end

  always @(posedge ap_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure("Timeout: ap_done never came before the cycle limit");
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  // One host transaction with ap_continue held off for hold cycles
  task automatic run_kernel(
    input kernel_pkg::addr_t  b0,
    input kernel_pkg::count_t c0,
    input kernel_pkg::addr_t  b1,
    input kernel_pkg::count_t c1,
    input int                 hold
  );
    compute_sum_max(b0, c0, b1, c1, exp_sum, exp_max);
    runs_started = runs_started + 1;
    buffer_0 <= b0;
    buffer_1 <= {16'h0, c0};
    buffer_2 <= b1;
    buffer_3 <= {16'h0, c1};
    ap_start <= 1'b1;
    @(posedge ap_clk);
    // ap_start level stays up until ap_ready
    while (!ap_ready) begin
      @(posedge ap_clk);
    end
    ap_start <= 1'b0;
    assert (!ap_idle) else begin
      report_failure("ap_idle stayed high after ap_ready");
    end
    while (!ap_done) begin
      @(posedge ap_clk);
    end
    assert (ready_count == runs_started) else begin
      report_failure($sformatf("Mismatch at %0t: %0d ap_ready pulses for %0d runs",
                               $time, ready_count, runs_started));
    end
    repeat (hold) begin
      @(posedge ap_clk);
      assert (ap_done && !ap_idle) else begin
        report_failure("ap_done fell or ap_idle rose before ap_continue");
      end
    end
    ap_continue <= 1'b1;
    @(posedge ap_clk);
    ap_continue <= 1'b0;
    @(posedge ap_clk);
    assert (ap_idle && !ap_done) else begin
      report_failure("kernel did not return to idle after ap_continue");
    end
  endtask

  initial begin
    kernel_pkg::addr_t  rb0;
    kernel_pkg::addr_t  rb1;
    kernel_pkg::count_t rc0;
    kernel_pkg::count_t rc1;
    int                 rhold;
    seed = SEED;
    // Random fill over every address
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem_array[a] = $random(seed);
    end
    ap_rst_n    <= 1'b0;
    ap_start    <= 1'b0;
    ap_continue <= 1'b0;
    buffer_0    <= '0;
    buffer_1    <= '0;
    buffer_2    <= '0;
    buffer_3    <= '0;
    repeat (8) @(posedge ap_clk);
    ap_rst_n <= 1'b1;
    @(posedge ap_clk);
    assert (ap_idle && !ap_ready && !ap_done && !mem_0_req && !mem_1_req) else begin
      report_failure("control or request outputs not at their reset values");
    end
    // Directed runs with start raised while the internal reset still holds
    run_kernel(32'd16, 16'd8, 32'd400, 16'd5, 3);
    run_kernel(32'd100, 16'd0, 32'd1018, 16'd12, 2);
    run_kernel(32'd700, 16'd9, 32'd0, 16'd0, 0);
    run_kernel(32'd0, 16'd0, 32'd0, 16'd0, 1);
    // Back-to-back random runs whose sums wrap past 2**32
    repeat (20) begin
      rb0   = $random(seed);
      rb1   = $random(seed);
      rc0   = 16'($unsigned($random(seed)) % 65);
      rc1   = 16'($unsigned($random(seed)) % 65);
      rhold = $random(seed) & 7;
      run_kernel(rb0, rc0, rb1, rc1, rhold);
    end
    $display("Test OK");
    $finish;
  end

endmodule : kernel_afu_tb

`default_nettype wire

// File: flist.f
source/kernel_pkg.sv
source/kernel_reset_sync.sv
source/kernel_read_engine.sv
source/kernel_control.sv
source/kernel_afu.sv
dv/kernel_mem_model.sv
dv/kernel_afu_tb.sv

// File: Makefile
# Verilator simulation of the read kernel

TOP := kernel_afu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
